// ==== src.f ====
verilog/bch_pkg.sv
verilog/syn_if.sv
verilog/loc_if.sv
verilog/syndrome_unit.sv
verilog/gf_serial_divider.sv
verilog/bm_solver.sv
verilog/chien_search.sv
verilog/bch_decoder.sv
verification/bch_decoder_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the BCH decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module bch_decoder_tb \
	-f src.f \
	-o sim_bch_decoder

./obj_dir/sim_bch_decoder > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== verification/bch_decoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_tb;
	import bch_pkg::*;

	// generator x^10+x^8+x^5+x^4+x^2+x+1
	localparam logic [10:0] GEN = 11'b10100110111;
	// cycles without progress before a wait gives up
	localparam int LIMIT = 1000;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_bit;
	logic in_ready;
	logic out_valid;
	logic out_bit;
	logic out_last;
	logic out_ready;
	logic decode_fail;

	logic bp_mode;
	logic hung;
	int errors;
	int checks;
	int tests;

	bch_decoder #(.T(3)) bch_decoder_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_bit(in_bit),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_bit(out_bit),
		.out_last(out_last),
		.out_ready(out_ready),
		.decode_fail(decode_fail)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// reference model
	// ========================================

	// remainder modulo the generator is zero for a valid codeword
	function automatic logic [9:0] poly_rem(word_t v);
		word_t r;
		r = v;
		for (int i = N - 1; i >= 10; i--) begin
			if (r[i]) begin
				r = r ^ (word_t'(GEN) << (i - 10));
			end
		end
		return r[9:0];
	endfunction

	// systematic codeword with data in the top five coefficients
	function automatic word_t encode(logic [4:0] data);
		word_t shifted;
		shifted = {data, 10'b0};
		return shifted | word_t'(poly_rem(shifted));
	endfunction

	// n distinct random bit positions
	function automatic word_t error_mask(int n);
		word_t m;
		int p;
		int placed;
		m = '0;
		placed = 0;
		while (placed < n) begin
			p = int'($urandom % N);
			if (!m[p]) begin
				m[p] = 1'b1;
				placed++;
			end
		end
		return m;
	endfunction

	task automatic check_equal(logic [31:0] got, logic [31:0] exp, string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	// ========================================
	// bus drivers
	// ========================================

	// r14 goes first
	// every call starts and ends 1 ns after a rising edge
	task automatic send_word(word_t w);
		int idx;
		int waited;
		idx = N - 1;
		waited = 0;
		in_valid = 1'b1;
		in_bit = w[idx];
		while (idx >= 0 && !hung) begin
			@(negedge clk);
			// accepted on the coming edge
			if (in_ready) begin
				idx--;
				waited = 0;
			end else begin
				waited++;
				if (waited > LIMIT) begin
					$display("timeout at %0t: decoder never took the next input bit", $time);
					hung = 1'b1;
					errors++;
				end
			end
			@(posedge clk);
			#1;
			if (idx < 0 || hung) begin
				in_valid = 1'b0;
			end else begin
				in_bit = w[idx];
			end
		end
		// input side closes once the whole word is in
		if (!hung) begin
			check_equal(32'(in_ready), 32'd0, "in_ready after last bit");
		end
	endtask

	task automatic recv_word(output word_t w, output logic fail);
		int cnt;
		int waited;
		cnt = 0;
		waited = 0;
		w = '0;
		fail = 1'b0;
		out_ready = bp_mode ? 1'($urandom) : 1'b1;
		while (cnt < N && !hung) begin
			@(negedge clk);
			if (out_valid && out_ready) begin
				w = {w[N-2:0], out_bit};
				check_equal(32'(out_last), 32'(cnt == N - 1), "out_last position");
				if (cnt == N - 1) begin
					fail = decode_fail;
				end
				cnt++;
				waited = 0;
			end else begin
				waited++;
				if (waited > LIMIT) begin
					$display("timeout at %0t: decoder produced no output bit", $time);
					hung = 1'b1;
					errors++;
				end
			end
			@(posedge clk);
			#1;
			out_ready = bp_mode ? 1'($urandom) : 1'b1;
		end
	endtask

	task automatic decode_one(word_t rx, output word_t got, output logic fail);
		fork
			send_word(rx);
			recv_word(got, fail);
		join
	endtask

	task automatic report_test(string name);
		tests++;
		$display("%s finished, %0d errors so far", name, errors);
	endtask

	// ========================================
	// directed tests
	// ========================================

	// n errors on a random codeword that must come back clean
	task automatic run_corrected(int n, string msg);
		word_t cw;
		word_t got;
		logic fail;
		cw = encode(5'($urandom));
		decode_one(cw ^ error_mask(n), got, fail);
		check_equal(32'(got), 32'(cw), msg);
		check_equal(32'(fail), 32'd0, {msg, " decode_fail"});
	endtask

	task automatic test_clean_words();
		repeat (4) run_corrected(0, "clean word");
		report_test("clean words");
	endtask

	task automatic test_single_error();
		repeat (6) run_corrected(1, "single error");
		report_test("single error");
	endtask

	task automatic test_multi_errors();
		repeat (4) run_corrected(2, "two errors");
		repeat (4) run_corrected(3, "three errors");
		report_test("two and three errors");
	endtask

	task automatic test_four_errors();
		word_t cw;
		word_t rx;
		word_t got;
		logic fail;
		repeat (6) begin
			cw = encode(5'($urandom));
			rx = cw ^ error_mask(4);
			decode_one(rx, got, fail);
			// unflagged result must still be a codeword near rx
			if (!fail) begin
				check_equal(32'(poly_rem(got)), 32'd0, "four errors, output not a codeword");
				check_equal(32'($countones(got ^ rx) <= 3), 32'd1,
					"four errors, output too far from received word");
			end
		end
		report_test("four errors");
	endtask

	task automatic test_back_pressure();
		// random stalls on the output side
		bp_mode = 1'b1;
		repeat (6) run_corrected(int'($urandom % 4), "back-pressure word");
		bp_mode = 1'b0;
		report_test("back-pressure");
	endtask

	task automatic test_back_to_back();
		word_t cws[5];
		word_t rxs[5];
		word_t got;
		logic fail;
		for (int i = 0; i < 5; i++) begin
			cws[i] = encode(5'($urandom));
			rxs[i] = cws[i] ^ error_mask(int'($urandom % 4));
		end
		fork
			begin
				for (int i = 0; i < 5; i++) begin
					send_word(rxs[i]);
				end
			end
			begin
				for (int i = 0; i < 5; i++) begin
					recv_word(got, fail);
					check_equal(32'(got), 32'(cws[i]), "back-to-back word");
					check_equal(32'(fail), 32'd0, "back-to-back decode_fail");
				end
			end
		join
		report_test("back-to-back");
	endtask

	initial begin
		void'($urandom(32'hb90f2b3d));
		reset = 1'b1;
		in_valid = 1'b0;
		in_bit = 1'b0;
		out_ready = 1'b0;
		bp_mode = 1'b0;
		hung = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// idle decoder takes input and offers no output
		check_equal(32'(in_ready), 32'd1, "in_ready after reset");
		check_equal(32'(out_valid), 32'd0, "out_valid after reset");

		test_clean_words();
		test_single_error();
		test_multi_errors();
		if (!hung) begin
			test_four_errors();
		end
		test_back_pressure();
		if (!hung) begin
			test_back_to_back();
		end

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !hung) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/bch_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// (15,5) BCH decoder, three stages each holding one word
module bch_decoder #(
	parameter int T = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic in_bit,
	output logic in_ready,
	output logic out_valid,
	output logic out_bit,
	output logic out_last,
	input  logic out_ready,
	output logic decode_fail
);

	syn_if #(.T(T)) syn_bus ();
	loc_if #(.T(T)) loc_bus ();

	// syndromes and word buffer
	syndrome_unit #(.T(T)) syndrome_unit_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_bit(in_bit),
		.in_ready(in_ready),
		.syn_out(syn_bus.src)
	);

	// error locator
	bm_solver #(.T(T)) bm_solver_i (
		.clk(clk),
		.reset(reset),
		.syn_in(syn_bus.dst),
		.loc_out(loc_bus.src)
	);

	// root search and output stream
	chien_search #(.T(T)) chien_search_i (
		.clk(clk),
		.reset(reset),
		.loc_in(loc_bus.dst),
		.out_valid(out_valid),
		.out_bit(out_bit),
		.out_last(out_last),
		.decode_fail(decode_fail),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

// ==== verilog/chien_search.sv ====
`timescale 1ns/1ps
`default_nettype none

module chien_search #(
	parameter int T = 3
) (
	input  logic clk,
	input  logic reset,
	loc_if.dst   loc_in,
	output logic out_valid,
	output logic out_bit,
	output logic out_last,
	output logic decode_fail,
	input  logic out_ready
);
	import bch_pkg::*;

	localparam int PW = $clog2(N);
	localparam int RW = $clog2(N + 1);
	localparam int DW = $clog2(2 * T + 1);

	chien_state_t state;
	logic ack_r;
	logic [PW-1:0] pos;
	logic [RW-1:0] root_cnt;

	// terms[k] = sigma_k * alpha^(-j*k) for current position j
	gf_t [T:0] terms;
	word_t word_r;
	logic [DW-1:0] deg_r;

	gf_t sum;
	logic is_root;
	logic step;

	// sigma(alpha^-j)
	always_comb begin
		sum = '0;
		for (int k = 0; k <= T; k++) begin
			sum = sum ^ terms[k];
		end
	end

	assign is_root = (sum == '0);
	assign step = out_valid && out_ready;

	assign out_valid = (state == CH_STREAM);
	// located position gets flipped on the way out
	assign out_bit = word_r[N-1] ^ is_root;
	assign out_last = out_valid && (pos == PW'(N - 1));
	// root count includes the last position itself
	assign decode_fail = out_last && ((int'(root_cnt) + int'(is_root)) != int'(deg_r));

	assign loc_in.ack = ack_r;

	// ========================================
	// control FSM
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CH_IDLE;
			ack_r <= 1'b0;
			pos <= '0;
			root_cnt <= '0;
		end else begin
			if (ack_r && !loc_in.req) begin
				ack_r <= 1'b0;
			end
			case (state)
				CH_IDLE: begin
					if (loc_in.req && !ack_r) begin
						state <= CH_SETUP;
					end
				end
				CH_SETUP: begin
					ack_r <= 1'b1;
					pos <= '0;
					root_cnt <= '0;
					state <= CH_STREAM;
				end
				CH_STREAM: begin
					// held here while the sink stalls
					if (step) begin
						pos <= pos + 1'b1;
						root_cnt <= root_cnt + RW'(is_root);
						if (out_last) begin
							state <= CH_DONE;
						end
					end
				end
				CH_DONE: begin
					if (!ack_r) begin
						state <= CH_IDLE;
					end
				end
				default: state <= CH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == CH_SETUP) begin
			word_r <= loc_in.word;
			deg_r <= loc_in.deg;
			// start at position N-1
			for (int k = 0; k <= T; k++) begin
				terms[k] <= gf_mul(loc_in.sigma[k], gf_alpha_pow(-(N - 1) * k));
			end
		end else if (step) begin
			word_r <= {word_r[N-2:0], 1'b0};
			// one position down
			for (int k = 0; k <= T; k++) begin
				terms[k] <= gf_mul(terms[k], gf_alpha_pow(k));
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> $stable(out_bit));

endmodule

`default_nettype wire

// ==== verilog/bm_solver.sv ====
`timescale 1ns/1ps
`default_nettype none

// binary berlekamp-massey with inversion
// d_r = sum sigma_i * S_(2r-i+1), factor = d_r / d_p
// sigma <- sigma + factor * beta
// beta <- x^2 * (change ? sigma_old : beta)
module bm_solver #(
	parameter int T = 3
) (
	input  logic clk,
	input  logic reset,
	syn_if.dst   syn_in,
	loc_if.src   loc_out
);
	import bch_pkg::*;

	localparam int CW = $clog2(M + 2);
	localparam int RW = $clog2(T + 1);
	localparam int DW = $clog2(2 * T + 1);

	bm_state_t state;
	logic [CW-1:0] cnt;
	logic [RW-1:0] r;
	logic syn_ack;
	logic loc_req;

	gf_t [2*T-1:0] syn_l;
	word_t word_l;
	gf_t [T:0] sigma;
	gf_t [T:0] beta;
	gf_t d_p;
	gf_t disc;
	logic [DW-1:0] len;

	gf_t [T:0] s_sel;
	gf_t disc_bits;
	gf_t factor;
	gf_t [T:0] sigma_nx;
	gf_t [T:0] beta_nx;
	logic change;

	logic div_start;
	logic div_done;
	gf_t d_p_inv;

	// ========================================
	// serial discrepancy
	// ========================================
	// cycles 1..M take sigma bit M-cnt, msb first
	always_comb begin
		int k;
		int b;
		b = M - int'(cnt);
		disc_bits = '0;
		for (int i = 0; i <= T; i++) begin
			k = 2 * int'(r) - i;
			if (k >= 0) begin
				s_sel[i] = syn_l[k];
			end else begin
				s_sel[i] = '0;
			end
			if (b >= 0 && b < M && sigma[i][b]) begin
				disc_bits = disc_bits ^ s_sel[i];
			end
		end
	end

	// update values used on cycle M+1
	always_comb begin
		factor = gf_mul(disc, d_p_inv);
		change = (disc != '0) && (int'(len) <= int'(r));
		for (int i = 0; i <= T; i++) begin
			sigma_nx[i] = sigma[i] ^ gf_mul(factor, beta[i]);
		end
		// terms above x^T never reach sigma
		if (change) begin
			beta_nx = {sigma[T-2:0], {(2*M){1'b0}}};
		end else begin
			beta_nx = {beta[T-2:0], {(2*M){1'b0}}};
		end
	end

	// inverse of d_p runs alongside the discrepancy bits
	assign div_start = (state == BM_ITERATE) && (cnt == '0);

	gf_serial_divider gf_serial_divider_i (
		.clk(clk),
		.reset(reset),
		.start(div_start),
		.numer(gf_t'(1)),
		.denom(d_p),
		.quot(d_p_inv),
		.done(div_done)
	);

	// ========================================
	// control FSM
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= BM_IDLE;
			cnt <= '0;
			r <= '0;
			syn_ack <= 1'b0;
			loc_req <= 1'b0;
		end else begin
			// release syndrome side once its req is gone
			if (syn_ack && !syn_in.req) begin
				syn_ack <= 1'b0;
			end
			case (state)
				BM_IDLE: begin
					if (syn_in.req && !syn_ack) begin
						state <= BM_LOAD;
					end
				end
				BM_LOAD: begin
					syn_ack <= 1'b1;
					cnt <= '0;
					r <= '0;
					state <= BM_ITERATE;
				end
				BM_ITERATE: begin
					if (cnt == CW'(M + 1)) begin
						cnt <= '0;
						if (r == RW'(T - 1)) begin
							state <= BM_HANDOFF;
							loc_req <= 1'b1;
						end else begin
							r <= r + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				BM_HANDOFF: begin
					if (loc_req && loc_out.ack) begin
						loc_req <= 1'b0;
					end else if (!loc_req && !loc_out.ack) begin
						state <= BM_IDLE;
					end
				end
				default: state <= BM_IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (state == BM_LOAD) begin
			syn_l <= syn_in.syn;
			word_l <= syn_in.word;
			// sigma = 1, beta = x, d_p = 1
			// iteration 0 then gives 1 + S1 x and beta x^2 or x^3
			sigma <= {{(T*M){1'b0}}, gf_t'(1)};
			beta <= {{((T-1)*M){1'b0}}, gf_t'(1), gf_t'(0)};
			d_p <= gf_t'(1);
			len <= '0;
		end else if (state == BM_ITERATE) begin
			if (cnt == '0) begin
				disc <= '0;
			end else if (int'(cnt) <= M) begin
				disc <= gf_mul(disc, ALPHA) ^ disc_bits;
			end else if (div_done) begin
				sigma <= sigma_nx;
				beta <= beta_nx;
				if (change) begin
					len <= DW'(2 * int'(r) + 1 - int'(len));
					d_p <= disc;
				end
			end
		end
	end

	assign syn_in.ack = syn_ack;
	assign loc_out.req = loc_req;
	assign loc_out.sigma = sigma;
	assign loc_out.deg = len;
	assign loc_out.word = word_l;

	assert property (@(posedge clk) disable iff (reset)
		$rose(loc_out.req) |-> (state != BM_ITERATE));
	// divider latency has to land exactly on the update cycle
	assert property (@(posedge clk) disable iff (reset)
		div_done |-> (state == BM_ITERATE && cnt == CW'(M + 1)));

endmodule

`default_nettype wire

// ==== verilog/gf_serial_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

// quot = numer / denom = numer * denom^(2^M - 2)
// one exponent bit per cycle, lsb first
// denom power is squared by shift-and-reduce each step
module gf_serial_divider (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  bch_pkg::gf_t numer,
	input  bch_pkg::gf_t denom,
	output bch_pkg::gf_t quot,
	output logic         done
);
	import bch_pkg::*;

	localparam int KW = $clog2(M);
	// exponent 2^M - 2 inverts any nonzero element
	localparam logic [M-1:0] EXP = M'((1 << M) - 2);

	logic busy;
	logic [KW-1:0] k;
	gf_t acc;
	gf_t pw;

	// step counter, done pulses on the cycle after the last step
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			k <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				k <= '0;
			end else if (busy) begin
				k <= k + 1'b1;
				if (k == KW'(M - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			acc <= numer;
			pw <= denom;
		end else if (busy) begin
			// pw runs through denom^(2^k)
			if (EXP[k]) begin
				acc <= gf_mul(acc, pw);
			end
			pw <= gf_mul(pw, pw);
		end
	end

	assign quot = acc;

	assert property (@(posedge clk) disable iff (reset) start |-> (denom != '0));

endmodule

`default_nettype wire

// ==== verilog/syndrome_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module syndrome_unit #(
	parameter int T = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic in_bit,
	output logic in_ready,
	syn_if.src   syn_out
);
	import bch_pkg::*;

	localparam int CW = $clog2(N + 1);

	logic [CW-1:0] cnt;
	logic busy;
	logic req;
	logic ack_q;
	logic ack_fall;
	logic accept;

	gf_t [2*T-1:0] syn_r;
	word_t word_r;

	// input port stays open until a whole word is in
	assign in_ready = !busy;
	assign accept = in_valid && in_ready;
	// handshake closes on the falling edge of ack
	assign ack_fall = ack_q && !syn_out.ack;

	// ========================================
	// horner accumulation and handshake
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			busy <= 1'b0;
			req <= 1'b0;
			ack_q <= 1'b0;
			syn_r <= '0;
		end else begin
			ack_q <= syn_out.ack;
			if (accept) begin
				// S_j <- S_j * alpha^j + r_i, highest coefficient first
				for (int j = 0; j < 2 * T; j++) begin
					syn_r[j] <= gf_mul(syn_r[j], gf_alpha_pow(j + 1)) ^ gf_t'(in_bit);
				end
				cnt <= cnt + 1'b1;
				// last bit of the word closes the input
				if (cnt == CW'(N - 1)) begin
					busy <= 1'b1;
					req <= 1'b1;
				end
			end
			// solver has latched, drop req
			if (req && syn_out.ack) begin
				req <= 1'b0;
			end
			if (ack_fall) begin
				busy <= 1'b0;
				cnt <= '0;
				syn_r <= '0;
			end
		end
	end

	// word buffer, r14 ends up in the top bit
	always_ff @(posedge clk) begin
		if (accept) begin
			word_r <= {word_r[N-2:0], in_bit};
		end
	end

	assign syn_out.req = req;
	assign syn_out.syn = syn_r;
	assign syn_out.word = word_r;

	// solver reads syn and word during the whole req phase
	assert property (@(posedge clk) disable iff (reset)
		(syn_out.req && $past(syn_out.req)) |-> ($stable(syn_out.syn) && $stable(syn_out.word)));

endmodule

`default_nettype wire

// ==== verilog/loc_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// solver to chien search
// four-phase req/ack, sigma, deg and word held while req is high
interface loc_if #(
	parameter int T = 3
);
	import bch_pkg::*;

	logic req;
	// sigma[k] is the x^k coefficient of the error locator
	gf_t [T:0] sigma;
	// locator length L from the solver
	logic [$clog2(2*T+1)-1:0] deg;
	word_t word;
	logic ack;

	modport src (
		output req,
		output sigma,
		output deg,
		output word,
		input  ack
	);

	modport dst (
		input  req,
		input  sigma,
		input  deg,
		input  word,
		output ack
	);

endinterface

`default_nettype wire

// ==== verilog/syn_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// syndrome unit to solver
// four-phase req/ack, syn and word held while req is high
interface syn_if #(
	parameter int T = 3
);
	import bch_pkg::*;

	logic req;
	// syn[j] holds S_(j+1)
	gf_t [2*T-1:0] syn;
	// word[i] is coefficient r_i
	word_t word;
	logic ack;

	modport src (
		output req,
		output syn,
		output word,
		input  ack
	);

	modport dst (
		input  req,
		input  syn,
		input  word,
		output ack
	);

endinterface

`default_nettype wire

// ==== verilog/bch_pkg.sv ====
`default_nettype none

package bch_pkg;

	// ========================================
	// field and code constants
	// ========================================

	// GF(2^4) built on x^4 + x + 1
	localparam int M = 4;
	localparam int N = (1 << M) - 1;

	typedef logic [M-1:0] gf_t;
	typedef logic [N-1:0] word_t;

	// low bits of the primitive polynomial, fed back when x^4 drops out
	localparam gf_t PRIM_LOW = 4'b0011;
	localparam gf_t ALPHA = 4'b0010;

	// solver FSM
	typedef enum logic [1:0] {
		BM_IDLE,
		BM_LOAD,
		BM_ITERATE,
		BM_HANDOFF
	} bm_state_t;

	// chien search FSM
	typedef enum logic [1:0] {
		CH_IDLE,
		CH_SETUP,
		CH_STREAM,
		CH_DONE
	} chien_state_t;

	// ========================================
	// field arithmetic
	// ========================================

	// shift-and-add product, reducing by the polynomial at every shift
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t p;
		gf_t s;
		p = '0;
		s = a;
		for (int i = 0; i < M; i++) begin
			if (b[i]) begin
				p = p ^ s;
			end
			s = {s[M-2:0], 1'b0} ^ (s[M-1] ? PRIM_LOW : gf_t'(0));
		end
		return p;
	endfunction

	// alpha^e, negative exponents folded back into 0..N-1
	function automatic gf_t gf_alpha_pow(int e);
		int k;
		gf_t v;
		k = ((e % N) + N) % N;
		v = gf_t'(1);
		for (int i = 0; i < N; i++) begin
			if (i < k) begin
				v = gf_mul(v, ALPHA);
			end
		end
		return v;
	endfunction

endpackage

`default_nettype wire
